/* page_mig_rd_arbiter.f */
verilog/page_mig_pkg.sv
verilog/engine_rd_if.sv
verilog/host_port_rd_mux.sv
verilog/mig_done_tracker.sv
verilog/page_mig_rd_arbiter.sv
test/tb_page_mig_rd_arbiter.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
    --top-module tb_page_mig_rd_arbiter \
    -f page_mig_rd_arbiter.f \
    -o sim_tb_page_mig_rd_arbiter || exit 1

out=$(./obj_dir/sim_tb_page_mig_rd_arbiter)
echo "$out"
echo "$out" | grep -q "Everything OK" && exit 0 || exit 1

/* test/tb_page_mig_rd_arbiter.sv */
// tb_page_mig_rd_arbiter, stimulus table, engine and host models, checks and watchdog
`timescale 1ns/100ps
`default_nettype none

module tb_page_mig_rd_arbiter;

    import page_mig_pkg::*;

    localparam int NUM_ENGINES = 4;
    localparam int CLK_PERIOD  = 4;
    localparam int NUM_ROWS    = 17;

    logic      axi4_mm_clk;
    logic      rst_n;
    axi_id_t   eng_ar_id     [NUM_ENGINES];
    mem_addr_t eng_ar_addr   [NUM_ENGINES];
    axi_user_t eng_ar_user   [NUM_ENGINES];
    logic      eng_ar_valid  [NUM_ENGINES];
    logic      eng_ar_ready  [NUM_ENGINES];
    axi_id_t   eng_r_id      [NUM_ENGINES];
    rd_data_t  eng_r_data    [NUM_ENGINES];
    logic      eng_r_valid   [NUM_ENGINES];
    mig_cnt_t  eng_done_cnt  [NUM_ENGINES];
    axi_id_t   host_ar_id    [NUM_PORTS];
    mem_addr_t host_ar_addr  [NUM_PORTS];
    axi_user_t host_ar_user  [NUM_PORTS];
    logic      host_ar_valid [NUM_PORTS];
    logic      host_ar_ready [NUM_PORTS];
    axi_id_t   host_r_id     [NUM_PORTS];
    rd_data_t  host_r_data   [NUM_PORTS];
    logic      host_r_valid  [NUM_PORTS];
    logic      host_r_ready  [NUM_PORTS];
    mig_cnt_t  total_mig_done_cnt;
    mig_cnt_t  mig_done_cnt;
    logic      mig_cycle_done;

    // stimulus table, one entry per row
    string       row_name       [NUM_ROWS];
    logic [3:0]  stim_ar_valid  [NUM_ROWS];   // per engine
    logic [1:0]  stim_ar_ready  [NUM_ROWS];   // per host port
    logic [1:0]  stim_r_valid   [NUM_ROWS];
    logic [1:0]  stim_r_host    [NUM_ROWS];   // id bit 11 per port
    logic [3:0]  stim_r_eng     [NUM_ROWS];   // {port 1 field, port 0 field}
    logic [31:0] stim_done      [NUM_ROWS];   // 8 bits per engine, engine 0 lowest
    // expected values
    logic [1:0]  exp_host_valid [NUM_ROWS];
    logic [3:0]  exp_win        [NUM_ROWS];   // global winner {port 1, port 0}
    logic [3:0]  exp_ar_ready   [NUM_ROWS];
    logic [3:0]  exp_r_valid    [NUM_ROWS];
    logic        exp_pulse      [NUM_ROWS];
    logic [7:0]  exp_done_cnt   [NUM_ROWS];   // after the row's clock edge
    logic [7:0]  exp_total      [NUM_ROWS];

    integer                 seed;
    int                     row_cnt;
    int                     errors;
    int                     row_errs;
    int                     rows_passed;
    int                     rows_failed;
    logic [NUM_ENGINES-1:0] accepted;   // handshake done in the last row

    page_mig_rd_arbiter #(
        .NUM_ENGINES (NUM_ENGINES)
    ) dut_i (.*);

    always #(CLK_PERIOD / 2) axi4_mm_clk = ~axi4_mm_clk;

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
            errors++;
            row_errs++;
        end
    endtask

    task automatic add_row(input string name, input logic [3:0] ar_valid,
                           input logic [1:0] ar_ready, input logic [1:0] r_valid,
                           input logic [1:0] r_host, input logic [3:0] r_eng,
                           input logic [31:0] done, input logic [1:0] x_hv,
                           input logic [3:0] x_win, input logic [3:0] x_rdy,
                           input logic [3:0] x_rv, input logic x_pulse,
                           input logic [7:0] x_cnt, input logic [7:0] x_total);
        row_name[row_cnt]       = name;
        stim_ar_valid[row_cnt]  = ar_valid;
        stim_ar_ready[row_cnt]  = ar_ready;
        stim_r_valid[row_cnt]   = r_valid;
        stim_r_host[row_cnt]    = r_host;
        stim_r_eng[row_cnt]     = r_eng;
        stim_done[row_cnt]      = done;
        exp_host_valid[row_cnt] = x_hv;
        exp_win[row_cnt]        = x_win;
        exp_ar_ready[row_cnt]   = x_rdy;
        exp_r_valid[row_cnt]    = x_rv;
        exp_pulse[row_cnt]      = x_pulse;
        exp_done_cnt[row_cnt]   = x_cnt;
        exp_total[row_cnt]      = x_total;
        row_cnt++;
    endtask

    task automatic build_table();
        //       name                   arv     ardy   rv     rhost  reng   done
        //       hv     win    rdy      rv      pulse cnt total
        add_row("idle", 4'b0000, 2'b00, 2'b00, 2'b00, 4'h0, 32'h00000000,
                2'b00, 4'b1000, 4'b0000, 4'b0000, 1'b0, 8'd0, 8'd0);
        add_row("port 0 priority", 4'b0011, 2'b01, 2'b00, 2'b00, 4'h0, 32'h00000000,
                2'b01, 4'b1000, 4'b0001, 4'b0000, 1'b0, 8'd0, 8'd0);
        add_row("port 1 priority", 4'b1100, 2'b10, 2'b00, 2'b00, 4'h0, 32'h00000000,
                2'b10, 4'b1000, 4'b0100, 4'b0000, 1'b0, 8'd0, 8'd0);
        add_row("upper engine of each half", 4'b1010, 2'b11, 2'b00, 2'b00, 4'h0, 32'h0,
                2'b11, 4'b1101, 4'b1010, 4'b0000, 1'b0, 8'd0, 8'd0);
        add_row("both ports busy", 4'b1111, 2'b11, 2'b00, 2'b00, 4'h0, 32'h00000000,
                2'b11, 4'b1000, 4'b0101, 4'b0000, 1'b0, 8'd0, 8'd0);
        add_row("both ports stalled", 4'b1111, 2'b00, 2'b00, 2'b00, 4'h0, 32'h00000000,
                2'b11, 4'b1000, 4'b0000, 4'b0000, 1'b0, 8'd0, 8'd0);
        add_row("port 1 stalled", 4'b0110, 2'b01, 2'b00, 2'b00, 4'h0, 32'h00000000,
                2'b11, 4'b1001, 4'b0010, 4'b0000, 1'b0, 8'd0, 8'd0);
        add_row("stall holds winner", 4'b0110, 2'b00, 2'b00, 2'b00, 4'h0, 32'h00000000,
                2'b11, 4'b1001, 4'b0000, 4'b0000, 1'b0, 8'd0, 8'd0);
        add_row("response to engine 0", 4'b0000, 2'b00, 2'b01, 2'b00, 4'h0, 32'h0,
                2'b00, 4'b1000, 4'b0000, 4'b0001, 1'b0, 8'd0, 8'd0);
        add_row("responses on both ports", 4'b0000, 2'b00, 2'b11, 2'b00, 4'b1101, 32'h0,
                2'b00, 4'b1000, 4'b0000, 4'b1010, 1'b0, 8'd0, 8'd0);
        add_row("host-owned response", 4'b0000, 2'b00, 2'b01, 2'b01, 4'h0, 32'h0,
                2'b00, 4'b1000, 4'b0000, 4'b0000, 1'b0, 8'd0, 8'd0);
        add_row("foreign engine field", 4'b0000, 2'b00, 2'b10, 2'b00, 4'h0, 32'h0,
                2'b00, 4'b1000, 4'b0000, 4'b0000, 1'b0, 8'd0, 8'd0);
        add_row("unequal done counts", 4'b0000, 2'b00, 2'b00, 2'b00, 4'h0, 32'h00010101,
                2'b00, 4'b1000, 4'b0000, 4'b0000, 1'b0, 8'd0, 8'd0);
        add_row("equal new done counts", 4'b0000, 2'b00, 2'b00, 2'b00, 4'h0, 32'h01010101,
                2'b00, 4'b1000, 4'b0000, 4'b0000, 1'b1, 8'd1, 8'd1);
        add_row("done counts held", 4'b0000, 2'b00, 2'b00, 2'b00, 4'h0, 32'h01010101,
                2'b00, 4'b1000, 4'b0000, 4'b0000, 1'b0, 8'd1, 8'd1);
        add_row("completion with traffic", 4'b1111, 2'b11, 2'b11, 2'b00, 4'b1001,
                32'h05050505, 2'b11, 4'b1000, 4'b0101, 4'b0110, 1'b1, 8'd2, 8'd5);
        add_row("second hold", 4'b0000, 2'b00, 2'b00, 2'b00, 4'h0, 32'h05050505,
                2'b00, 4'b1000, 4'b0000, 4'b0000, 1'b0, 8'd2, 8'd5);
    endtask

    task automatic clear_inputs();
        axi4_mm_clk = 1'b0;
        rst_n       = 1'b0;
        accepted    = '0;
        for (int e = 0; e < NUM_ENGINES; e++) begin
            eng_ar_id[e]    = '0;
            eng_ar_addr[e]  = '0;
            eng_ar_user[e]  = '0;
            eng_ar_valid[e] = 1'b0;
            eng_done_cnt[e] = '0;
        end
        for (int p = 0; p < NUM_PORTS; p++) begin
            host_ar_ready[p] = 1'b0;
            host_r_id[p]     = '0;
            host_r_data[p]   = '0;
            host_r_valid[p]  = 1'b0;
        end
    endtask

    task automatic apply_row(input int r);
        logic [31:0] rnd;
        for (int e = 0; e < NUM_ENGINES; e++) begin
            // an engine keeps its request until it is accepted
            if (!eng_ar_valid[e] || accepted[e]) begin
                eng_ar_id[e]              = axi_id_t'($random(seed));
                eng_ar_id[e][ID_HOST_BIT] = 1'b1;   // must come out cleared
                eng_ar_addr[e]            = {$random(seed), $random(seed)};
                eng_ar_user[e]            = axi_user_t'($random(seed));
            end
            eng_ar_valid[e] = stim_ar_valid[r][e];
            eng_done_cnt[e] = mig_cnt_t'(stim_done[r][8*e +: 8]);
        end
        for (int p = 0; p < NUM_PORTS; p++) begin
            rnd              = $random(seed);
            host_ar_ready[p] = stim_ar_ready[r][p];
            host_r_valid[p]  = stim_r_valid[r][p];
            host_r_id[p]     = {stim_r_host[r][p], rnd[10:8], stim_r_eng[r][2*p +: 2], rnd[5:0]};
            host_r_data[p]   = {$random(seed), $random(seed)};
        end
    endtask

    // outputs that follow the inputs within the cycle
    task automatic check_comb(input int r);
        axi_id_t exp_id;
        int      w;
        for (int p = 0; p < NUM_PORTS; p++) begin
            check_value($sformatf("host_ar_valid[%0d]", p), 64'(host_ar_valid[p]),
                        64'(exp_host_valid[r][p]));
            check_value($sformatf("host_r_ready[%0d]", p), 64'(host_r_ready[p]), 64'd1);
            if (exp_host_valid[r][p]) begin
                w                   = int'(exp_win[r][2*p +: 2]);
                exp_id              = eng_ar_id[w];
                exp_id[ID_HOST_BIT] = 1'b0;
                check_value($sformatf("host_ar_id[%0d]", p), 64'(host_ar_id[p]), 64'(exp_id));
                check_value($sformatf("host_ar_addr[%0d]", p), host_ar_addr[p], eng_ar_addr[w]);
                check_value($sformatf("host_ar_user[%0d]", p), 64'(host_ar_user[p]),
                            64'(eng_ar_user[w]));
            end
        end
        for (int e = 0; e < NUM_ENGINES; e++) begin
            check_value($sformatf("eng_ar_ready[%0d]", e), 64'(eng_ar_ready[e]),
                        64'(exp_ar_ready[r][e]));
            check_value($sformatf("eng_r_valid[%0d]", e), 64'(eng_r_valid[e]),
                        64'(exp_r_valid[r][e]));
            if (exp_r_valid[r][e]) begin
                check_value($sformatf("eng_r_data[%0d]", e), eng_r_data[e], host_r_data[e/2]);
                check_value($sformatf("eng_r_id[%0d]", e), 64'(eng_r_id[e]),
                            64'(host_r_id[e/2]));
            end
            accepted[e] = eng_ar_valid[e] & eng_ar_ready[e];
        end
        check_value("mig_cycle_done", 64'(mig_cycle_done), 64'(exp_pulse[r]));
    endtask

    task automatic check_regs(input int r);
        check_value("mig_done_cnt", mig_done_cnt, 64'(exp_done_cnt[r]));
        check_value("total_mig_done_cnt", total_mig_done_cnt, 64'(exp_total[r]));
    endtask

    initial begin
        seed        = 32'h1561;
        row_cnt     = 0;
        errors      = 0;
        rows_passed = 0;
        rows_failed = 0;
        clear_inputs();
        build_table();
        repeat (2) @(posedge axi4_mm_clk);
        @(negedge axi4_mm_clk);
        rst_n = 1'b1;
        for (int r = 0; r < row_cnt; r++) begin
            row_errs = 0;
            apply_row(r);
            #1;                         // settle, well before the rising edge
            check_comb(r);
            @(negedge axi4_mm_clk);     // tracker registers updated by now
            check_regs(r);
            if (row_errs == 0) begin
                rows_passed++;
            end else begin
                rows_failed++;
            end
            $display("test %0d %s: %s", r, row_name[r], (row_errs == 0) ? "ok" : "mismatch");
        end
        $display("%0d tests, %0d passed, %0d failed, %0d mismatches",
                 row_cnt, rows_passed, rows_failed, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // eight clock periods per table row is far more than a row needs
    initial begin
        #(NUM_ROWS * 8 * CLK_PERIOD);
        $display("timeout: the stimulus table did not finish in time");
        $display("Something failed");
        $finish;
    end

endmodule : tb_page_mig_rd_arbiter

`default_nettype wire

/* verilog/engine_rd_if.sv */
// engine_rd_if, one engine's read request and read response bundle
`timescale 1ns/100ps
`default_nettype none

interface engine_rd_if;

    import page_mig_pkg::*;

    // read address channel
    axi_id_t   ar_id;
    mem_addr_t ar_addr;
    axi_user_t ar_user;
    logic      ar_valid;
    logic      ar_ready;

    // read data channel, no back-pressure
    rd_data_t  r_data;
    axi_id_t   r_id;
    logic      r_valid;

    // engine side issues requests and takes responses
    modport engine (
        output ar_id, ar_addr, ar_user, ar_valid,
        input  ar_ready, r_id, r_data, r_valid
    );

    // host port mux side
    modport port (
        input  ar_id, ar_addr, ar_user, ar_valid,
        output ar_ready, r_id, r_data, r_valid
    );

endinterface : engine_rd_if

`default_nettype wire

/* verilog/host_port_rd_mux.sv */
// host_port_rd_mux, fixed-priority AR arbiter and R router for one host port
`timescale 1ns/100ps
`default_nettype none

module host_port_rd_mux #(
    parameter int NUM_ENGINES = 4,
    parameter int PORT_IDX    = 0
) (
    engine_rd_if.port             rd_engine [NUM_ENGINES/page_mig_pkg::NUM_PORTS],

    output page_mig_pkg::axi_id_t   host_ar_id,
    output page_mig_pkg::mem_addr_t host_ar_addr,
    output page_mig_pkg::axi_user_t host_ar_user,
    output logic                    host_ar_valid,
    input  logic                    host_ar_ready,

    input  page_mig_pkg::axi_id_t   host_r_id,
    input  page_mig_pkg::rd_data_t  host_r_data,
    input  logic                    host_r_valid,
    output logic                    host_r_ready
);

    import page_mig_pkg::*;

    localparam int ENG_PER_PORT = NUM_ENGINES / NUM_PORTS;
    localparam int ENG_IDX_W    = $clog2(NUM_ENGINES);
    localparam int LOC_W        = (ENG_PER_PORT > 1) ? $clog2(ENG_PER_PORT) : 1;
    localparam int BASE_IDX     = PORT_IDX * ENG_PER_PORT;  // global index of local engine 0

    axi_id_t              eng_ar_id   [ENG_PER_PORT];
    mem_addr_t            eng_ar_addr [ENG_PER_PORT];
    axi_user_t            eng_ar_user [ENG_PER_PORT];
    logic [ENG_PER_PORT-1:0] eng_ar_valid;
    logic [ENG_PER_PORT-1:0] eng_ar_ready;
    logic [ENG_PER_PORT-1:0] eng_r_hit;
    logic [ENG_PER_PORT-1:0] low_valid;    // lowest asking engine, one-hot

    logic [LOC_W-1:0]     win_idx;         // local index of the granted engine
    logic                 rsp_to_engine;   // response is engine-owned

    // flatten the interface array so it can be indexed by win_idx
    for (genvar g = 0; g < ENG_PER_PORT; g++) begin : g_eng
        assign eng_ar_id[g]    = rd_engine[g].ar_id;
        assign eng_ar_addr[g]  = rd_engine[g].ar_addr;
        assign eng_ar_user[g]  = rd_engine[g].ar_user;
        assign eng_ar_valid[g] = rd_engine[g].ar_valid;

        assign rd_engine[g].ar_ready = eng_ar_ready[g];
        assign rd_engine[g].r_id     = host_r_id;     // id and data broadcast
        assign rd_engine[g].r_data   = host_r_data;
        assign rd_engine[g].r_valid  = eng_r_hit[g];
    end

    // lowest local index wins, local 0 when nobody asks
    always_comb begin
        win_idx = '0;
        for (int i = ENG_PER_PORT - 1; i >= 0; i--) begin
            if (eng_ar_valid[i]) begin
                win_idx = LOC_W'(i);
            end
        end
    end

    // request path is purely combinational, stall holds the winner
    always_comb begin
        host_ar_id              = eng_ar_id[win_idx];
        host_ar_id[ID_HOST_BIT] = 1'b0;   // mark as engine-owned
        host_ar_addr            = eng_ar_addr[win_idx];
        host_ar_user            = eng_ar_user[win_idx];
        host_ar_valid           = eng_ar_valid[win_idx];

        eng_ar_ready          = '0;
        eng_ar_ready[win_idx] = host_ar_ready;
    end

    assign host_r_ready  = 1'b1;
    assign rsp_to_engine = host_r_valid & ~host_r_id[ID_HOST_BIT];

    // steer r_valid by the engine field of the id
    always_comb begin
        for (int i = 0; i < ENG_PER_PORT; i++) begin
            eng_r_hit[i] = rsp_to_engine &&
                (host_r_id[ID_ENG_LSB +: ENG_IDX_W] == ENG_IDX_W'(BASE_IDX + i));
        end
    end

    assign low_valid = eng_ar_valid & (~eng_ar_valid + ENG_PER_PORT'(1));

    // grant reaches at most one engine, and only the lowest one asking
    always_comb begin
        a_one_ar_ready: assert ($onehot0(eng_ar_ready) && (eng_ar_valid == '0 ||
                eng_ar_ready == (host_ar_ready ? low_valid : '0)))
            else $error("port %0d granted ar_ready to the wrong engines", PORT_IDX);
    end

endmodule : host_port_rd_mux

`default_nettype wire

/* verilog/mig_done_tracker.sv */
// mig_done_tracker, migration cycle completion detect and done counters
`timescale 1ns/100ps
`default_nettype none

module mig_done_tracker #(
    parameter int NUM_ENGINES = 4
) (
    input  logic                   axi4_mm_clk,
    input  logic                   rst_n,

    input  page_mig_pkg::mig_cnt_t engine_done_cnt [NUM_ENGINES],

    output page_mig_pkg::mig_cnt_t total_mig_done_cnt,
    output page_mig_pkg::mig_cnt_t mig_done_cnt,     // CSR counter of completed cycles
    output logic                   mig_cycle_done
);

    import page_mig_pkg::*;

    mig_cnt_t rec_done_cnt [NUM_ENGINES];   // counts seen at the last completion
    logic     all_same;
    logic     any_new;

    // every engine at the same count, and that count not yet recorded
    always_comb begin
        all_same = 1'b1;
        any_new  = 1'b0;
        for (int i = 0; i < NUM_ENGINES; i++) begin
            if (engine_done_cnt[i] != engine_done_cnt[0]) begin
                all_same = 1'b0;
            end
            if (engine_done_cnt[i] != rec_done_cnt[i]) begin
                any_new = 1'b1;
            end
        end
    end

    assign mig_cycle_done = all_same & any_new;

    always_ff @(posedge axi4_mm_clk) begin
        if (!rst_n) begin
            rec_done_cnt       <= '{default: '0};
            total_mig_done_cnt <= '0;
            mig_done_cnt       <= '0;
        end else if (mig_cycle_done) begin
            rec_done_cnt       <= engine_done_cnt;    // clears the condition next cycle
            total_mig_done_cnt <= engine_done_cnt[0]; // all equal, any one will do
            mig_done_cnt       <= mig_done_cnt + 1'b1;
        end
    end

    // recording the counts must drop the pulse after one cycle
    a_single_pulse: assert property (
        @(posedge axi4_mm_clk) disable iff (!rst_n)
        mig_cycle_done |=> !mig_cycle_done
    ) else $error("mig_cycle_done held for more than one cycle");

endmodule : mig_done_tracker

`default_nettype wire

/* verilog/page_mig_pkg.sv */
// widths, vector types and ID field constants shared by the read arbiter
`default_nettype none

package page_mig_pkg;

    // host and engine read channel fields
    typedef logic [11:0] axi_id_t;     // AR/R transaction id
    typedef logic [63:0] mem_addr_t;   // byte address
    typedef logic [5:0]  axi_user_t;   // cacheability hint on AR
    typedef logic [63:0] rd_data_t;    // one read data beat

    // per-engine migration completion count
    typedef logic [63:0] mig_cnt_t;

    // id bit 11 set marks a host-owned transaction
    localparam int ID_HOST_BIT = 11;

    // engine index field starts here in the id
    localparam int ID_ENG_LSB = 6;

    // host read ports, each serving one half of the engines
    localparam int NUM_PORTS = 2;

endpackage : page_mig_pkg

`default_nettype wire

/* verilog/page_mig_rd_arbiter.sv */
// page_mig_rd_arbiter, top level with engine interfaces, host port muxes and tracker
`timescale 1ns/100ps
`default_nettype none

module page_mig_rd_arbiter #(
    parameter int NUM_ENGINES = 4   // even, at least 2
) (
    input  logic                    axi4_mm_clk,
    input  logic                    rst_n,

    // engine read request side
    input  page_mig_pkg::axi_id_t   eng_ar_id    [NUM_ENGINES],
    input  page_mig_pkg::mem_addr_t eng_ar_addr  [NUM_ENGINES],
    input  page_mig_pkg::axi_user_t eng_ar_user  [NUM_ENGINES],
    input  logic                    eng_ar_valid [NUM_ENGINES],
    output logic                    eng_ar_ready [NUM_ENGINES],

    // engine read response side
    output page_mig_pkg::axi_id_t   eng_r_id     [NUM_ENGINES],
    output page_mig_pkg::rd_data_t  eng_r_data   [NUM_ENGINES],
    output logic                    eng_r_valid  [NUM_ENGINES],

    input  page_mig_pkg::mig_cnt_t  eng_done_cnt [NUM_ENGINES],

    // host read ports
    output page_mig_pkg::axi_id_t   host_ar_id    [page_mig_pkg::NUM_PORTS],
    output page_mig_pkg::mem_addr_t host_ar_addr  [page_mig_pkg::NUM_PORTS],
    output page_mig_pkg::axi_user_t host_ar_user  [page_mig_pkg::NUM_PORTS],
    output logic                    host_ar_valid [page_mig_pkg::NUM_PORTS],
    input  logic                    host_ar_ready [page_mig_pkg::NUM_PORTS],

    input  page_mig_pkg::axi_id_t   host_r_id     [page_mig_pkg::NUM_PORTS],
    input  page_mig_pkg::rd_data_t  host_r_data   [page_mig_pkg::NUM_PORTS],
    input  logic                    host_r_valid  [page_mig_pkg::NUM_PORTS],
    output logic                    host_r_ready  [page_mig_pkg::NUM_PORTS],

    // completion bookkeeping
    output page_mig_pkg::mig_cnt_t  total_mig_done_cnt,
    output page_mig_pkg::mig_cnt_t  mig_done_cnt,
    output logic                    mig_cycle_done
);

    import page_mig_pkg::*;

    localparam int ENG_PER_PORT = NUM_ENGINES / NUM_PORTS;

    // one interface array per host port, together covering all engines
    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        engine_rd_if port_if [ENG_PER_PORT] ();

        for (genvar j = 0; j < ENG_PER_PORT; j++) begin : g_eng
            // engine p*ENG_PER_PORT + j lives on this port
            assign port_if[j].ar_id    = eng_ar_id[p*ENG_PER_PORT + j];
            assign port_if[j].ar_addr  = eng_ar_addr[p*ENG_PER_PORT + j];
            assign port_if[j].ar_user  = eng_ar_user[p*ENG_PER_PORT + j];
            assign port_if[j].ar_valid = eng_ar_valid[p*ENG_PER_PORT + j];

            assign eng_ar_ready[p*ENG_PER_PORT + j] = port_if[j].ar_ready;
            assign eng_r_id[p*ENG_PER_PORT + j]     = port_if[j].r_id;
            assign eng_r_data[p*ENG_PER_PORT + j]   = port_if[j].r_data;
            assign eng_r_valid[p*ENG_PER_PORT + j]  = port_if[j].r_valid;
        end

        host_port_rd_mux #(
            .NUM_ENGINES (NUM_ENGINES),
            .PORT_IDX    (p)
        ) u_port_mux (
            .rd_engine     (port_if),
            .host_ar_id    (host_ar_id[p]),
            .host_ar_addr  (host_ar_addr[p]),
            .host_ar_user  (host_ar_user[p]),
            .host_ar_valid (host_ar_valid[p]),
            .host_ar_ready (host_ar_ready[p]),
            .host_r_id     (host_r_id[p]),
            .host_r_data   (host_r_data[p]),
            .host_r_valid  (host_r_valid[p]),
            .host_r_ready  (host_r_ready[p])
        );
    end

    // all engines report into one tracker
    mig_done_tracker #(
        .NUM_ENGINES (NUM_ENGINES)
    ) u_done_tracker (
        .axi4_mm_clk        (axi4_mm_clk),
        .rst_n              (rst_n),
        .engine_done_cnt    (eng_done_cnt),
        .total_mig_done_cnt (total_mig_done_cnt),
        .mig_done_cnt       (mig_done_cnt),
        .mig_cycle_done     (mig_cycle_done)
    );

endmodule : page_mig_rd_arbiter

`default_nettype wire
